// ==== dispatch_core.f ====
isa_pkg.sv
sched_pkg.sv
instr_decoder.sv
reg_file_status.sv
dispatch.sv
fu_status_table.sv
exec_units.sv
dispatch_core.sv
tb_dispatch_core.sv

// ==== tb_dispatch_core.sv ====
module tb_dispatch_core import isa_pkg::*, sched_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INSTR         = 400;
    localparam int CLK_HALF        = 20;
    localparam int WATCHDOG_CYCLES = N_INSTR * 10 + 200;

    // expected result of one register-writing instruction
    typedef struct packed {
        fu_tag_t tag;
        word_t   value;
    } expect_t;

    logic  CLK;
    logic  nRST;
    logic  in_valid;
    word_t in_instr;
    logic  in_ready;
    wb_t   alu_wb;
    wb_t   ls_wb;

    // sequential reference state
    word_t   ref_regs [32];
    word_t   ref_mem [MEM_WORDS];
    expect_t exp_q [32][$];

    int   val_errs;
    int   proto_errs;
    int   accepted_writes;
    int   broadcasts;
    int   alu_out;
    int   ls_out;
    logic any_accept;

    dispatch_core u_dispatch_core (.*);

    always #(CLK_HALF) CLK = ~CLK;

    function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input regidx_t rd, input regidx_t rs1, input regidx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                    input regidx_t rd, input regidx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input regidx_t rs1, input regidx_t rs2,
                                    input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    function automatic int outstanding();
        int sum;
        sum = 0;
        for (int r = 0; r < 32; r++) begin
            sum += exp_q[r].size();
        end
        return sum;
    endfunction

    // kind: 0 add, 1 sub, 2 and, 3 xor, 4 addi, 5 lw, 6 sw, other unknown
    task automatic record_accept(input int kind, input regidx_t rd, input regidx_t rs1,
                                 input regidx_t rs2, input logic [11:0] imm);
        word_t   a;
        word_t   b;
        word_t   simm;
        word_t   addr;
        word_t   res;
        fu_tag_t unit;
        expect_t e;
        a    = ref_regs[rs1];
        b    = ref_regs[rs2];
        simm = {{20{imm[11]}}, imm};
        addr = a + simm;
        res  = '0;
        unit = TAG_ALU;
        case (kind)
            0: res = a + b;
            1: res = a - b;
            2: res = a & b;
            3: res = a ^ b;
            4: res = a + simm;
            5: begin
                res  = ref_mem[addr[5:2]];
                unit = TAG_LS;
            end
            6: ref_mem[addr[5:2]] = b;
            default: unit = TAG_NONE;
        endcase
        any_accept = 1'b1;
        if (kind <= 5 && rd != '0) begin
            ref_regs[rd] = res;
            e = {unit, res};
            exp_q[rd].push_back(e);
            accepted_writes++;
            if (unit == TAG_ALU) begin
                alu_out++;
            end else begin
                ls_out++;
            end
            a_one_writer: assert (exp_q[rd].size() == 1) else begin
                proto_errs++;
                $display("two writers outstanding for x%0d at %0t", rd, $time);
            end
            a_unit_depth: assert (alu_out <= 2 && ls_out <= 2) else begin
                proto_errs++;
                $display("more than two instructions outstanding in one unit at %0t", $time);
            end
        end
    endtask

    // hold valid and data until the DUT takes the instruction
    task automatic send_instr(input word_t instr, input int kind, input regidx_t rd,
                              input regidx_t rs1, input regidx_t rs2, input logic [11:0] imm);
        @(negedge CLK);
        in_valid = 1'b1;
        in_instr = instr;
        #1;
        while (!in_ready) begin
            @(negedge CLK);
            #1;
        end
        record_accept(kind, rd, rs1, rs2, imm);
    endtask

    task automatic check_wb(input wb_t wb, input fu_tag_t unit, input string name);
        expect_t e;
        broadcasts++;
        if (unit == TAG_ALU) begin
            alu_out--;
        end else begin
            ls_out--;
        end
        a_wb_tag: assert (wb.tag == unit) else begin
            val_errs++;
            $display("Error %0t %s.tag: got %0d, expected %0d", $time, name, wb.tag, unit);
        end
        a_no_x0: assert (wb.rd != '0) else begin
            proto_errs++;
            $display("%s broadcast to x0 at %0t", name, $time);
        end
        a_expected: assert (exp_q[wb.rd].size() != 0) else begin
            proto_errs++;
            $display("%s broadcast to x%0d with nothing outstanding at %0t", name, wb.rd, $time);
        end
        if (exp_q[wb.rd].size() != 0) begin
            e = exp_q[wb.rd].pop_front();
            a_wb_unit: assert (e.tag == unit) else begin
                proto_errs++;
                $display("x%0d written by the wrong unit at %0t", wb.rd, $time);
            end
            a_wb_value: assert (wb.value == e.value) else begin
                val_errs++;
                $display("Error %0t %s.value: got %h, expected %h",
                         $time, name, wb.value, e.value);
            end
        end
    endtask

    // sampled at the rising edge, before any register update lands
    always @(posedge CLK) begin
        if (nRST) begin
            if (!any_accept) begin
                a_reset_idle: assert (in_ready && !alu_wb.valid && !ls_wb.valid) else begin
                    proto_errs++;
                    $display("not idle before the first instruction at %0t", $time);
                end
            end
            if (alu_wb.valid) begin
                check_wb(alu_wb, TAG_ALU, "alu_wb");
            end
            if (ls_wb.valid) begin
                check_wb(ls_wb, TAG_LS, "ls_wb");
            end
        end
    end

    initial begin
        int          kind;
        regidx_t     rd;
        regidx_t     rs1;
        regidx_t     rs2;
        logic [11:0] imm;
        word_t       instr;
        void'($urandom(32'h4e1b_7a09));
        CLK             = 1'b0;
        nRST            = 1'b0;
        in_valid        = 1'b0;
        in_instr        = '0;
        val_errs        = 0;
        proto_errs      = 0;
        accepted_writes = 0;
        broadcasts      = 0;
        alu_out         = 0;
        ls_out          = 0;
        any_accept      = 1'b0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        for (int m = 0; m < MEM_WORDS; m++) begin
            ref_mem[m] = '0;
        end
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        for (int n = 0; n < N_INSTR; n++) begin
            kind = $urandom_range(0, 7);
            // unknown opcodes stay rare
            if (kind == 7 && $urandom_range(0, 1) == 1) begin
                kind = 4;
            end
            rd  = regidx_t'($urandom_range(0, 7));
            rs1 = regidx_t'($urandom_range(0, 7));
            rs2 = regidx_t'($urandom_range(0, 7));
            imm = 12'($urandom);
            if (kind == 5 || kind == 6) begin
                // small word offsets, often from x0, so loads hit earlier stores
                imm = {6'b0, 4'($urandom_range(0, 15)), 2'b00};
                if ($urandom_range(0, 1) == 1) begin
                    rs1 = '0;
                end
            end
            case (kind)
                0: instr = enc_r(F7_BASE, F3_ADD, rd, rs1, rs2);
                1: instr = enc_r(F7_ALT, F3_ADD, rd, rs1, rs2);
                2: instr = enc_r(F7_BASE, F3_AND, rd, rs1, rs2);
                3: instr = enc_r(F7_BASE, F3_XOR, rd, rs1, rs2);
                4: instr = enc_i(OPC_OP_IMM, F3_ADD, rd, rs1, imm);
                5: instr = enc_i(OPC_LOAD, F3_WORD, rd, rs1, imm);
                6: instr = enc_s(rs1, rs2, imm);
                default: instr = enc_i(7'b1110011, 3'b000, rd, rs1, imm);
            endcase
            send_instr(instr, kind, rd, rs1, rs2, imm);
            if ($urandom_range(0, 7) == 0) begin
                @(negedge CLK);
                in_valid = 1'b0;
            end
        end
        @(negedge CLK);
        in_valid = 1'b0;

        // drain, then watch a while for stray broadcasts
        while (outstanding() != 0) begin
            @(posedge CLK);
        end
        repeat (20) @(posedge CLK);
        a_all_done: assert (accepted_writes == broadcasts) else begin
            proto_errs++;
            $display("%0d writing instructions accepted but %0d broadcasts seen",
                     accepted_writes, broadcasts);
        end

        $display("errors: %0d value, %0d other", val_errs, proto_errs);
        if (val_errs + proto_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        proto_errs++;
        $display("timeout after %0d cycles, %0d results still outstanding",
                 WATCHDOG_CYCLES, outstanding());
        $display("errors: %0d value, %0d other", val_errs, proto_errs);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== dispatch_core.sv ====
module dispatch_core import isa_pkg::*, sched_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  in_valid,
    input  word_t in_instr,
    output logic  in_ready,
    output wb_t   alu_wb,
    output wb_t   ls_wb
);

    // register file read ports
    regidx_t rd_addr1;
    regidx_t rd_addr2;
    regidx_t rd_addr3;
    fu_tag_t rd_tag1;
    fu_tag_t rd_tag2;
    fu_tag_t rd_tag3;
    word_t   rd_val1;
    word_t   rd_val2;

    // status update on acceptance
    logic    set_en;
    regidx_t set_rd;
    fu_tag_t set_tag;

    // status table allocation and issue
    logic      alloc_alu;
    logic      alloc_ls;
    fust_row_t alloc_row;
    logic      alu_busy;
    logic      ls_busy;
    logic      alu_issue;
    fust_row_t alu_row;
    logic      ls_issue;
    fust_row_t ls_row;
    logic      ls_ready;

    dispatch u_dispatch (.*);

    reg_file_status u_reg_file_status (.*);

    fu_status_table u_fu_status_table (.*);

    exec_units u_exec_units (.*);

endmodule

// ==== exec_units.sv ====
module exec_units import isa_pkg::*, sched_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      alu_issue,
    input  fust_row_t alu_row,
    input  logic      ls_issue,
    input  fust_row_t ls_row,
    output logic      ls_ready,
    output wb_t       alu_wb,
    output wb_t       ls_wb
);

    word_t     alu_res;
    ls_state_t ls_state;
    lscnt_t    ls_cnt;
    fust_row_t ls_cur;
    word_t     ls_addr;
    memidx_t   ls_idx;
    word_t     mem [MEM_WORDS];

    always_comb begin
        case (alu_row.op)
            OP_SUB:  alu_res = alu_row.val1 - alu_row.val2;
            OP_AND:  alu_res = alu_row.val1 & alu_row.val2;
            OP_XOR:  alu_res = alu_row.val1 ^ alu_row.val2;
            OP_ADDI: alu_res = alu_row.val1 + alu_row.imm;
            default: alu_res = alu_row.val1 + alu_row.val2;
        endcase
    end

    // single stage, result shows up the cycle after issue
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            alu_wb <= '0;
        end else begin
            alu_wb.valid <= alu_issue && (alu_row.rd != '0);
            alu_wb.tag   <= TAG_ALU;
            if (alu_issue) begin
                alu_wb.rd    <= alu_row.rd;
                alu_wb.value <= alu_res;
            end
        end
    end

    assign ls_ready = (ls_state == LS_IDLE);

    // byte address to word index
    assign ls_addr = ls_cur.val1 + ls_cur.imm;
    assign ls_idx  = ls_addr[5:2];

    always_ff @(posedge CLK) begin
        if (ls_issue) begin
            ls_cur <= ls_row;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ls_state <= LS_IDLE;
            ls_cnt   <= '0;
            ls_wb    <= '0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            ls_wb.valid <= 1'b0;
            ls_wb.tag   <= TAG_LS;
            case (ls_state)
                LS_IDLE: begin
                    if (ls_issue) begin
                        ls_state <= LS_BUSY;
                        ls_cnt   <= lscnt_t'(LS_LATENCY - 1);
                    end
                end
                LS_BUSY: begin
                    if (ls_cnt == '0) begin
                        // memory access happens at the end of the latency
                        ls_state <= LS_IDLE;
                        if (ls_cur.op == OP_SW) begin
                            mem[ls_idx] <= ls_cur.val2;
                        end else if (ls_cur.rd != '0) begin
                            ls_wb.valid <= 1'b1;
                            ls_wb.rd    <= ls_cur.rd;
                            ls_wb.value <= mem[ls_idx];
                        end
                    end else begin
                        ls_cnt <= ls_cnt - 1'b1;
                    end
                end
                default: ls_state <= LS_IDLE;
            endcase
        end
    end

endmodule

// ==== fu_status_table.sv ====
module fu_status_table import isa_pkg::*, sched_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      alloc_alu,
    input  logic      alloc_ls,
    input  fust_row_t alloc_row,
    output logic      alu_busy,
    output logic      ls_busy,
    input  wb_t       alu_wb,
    input  wb_t       ls_wb,
    output logic      alu_issue,
    output fust_row_t alu_row,
    output logic      ls_issue,
    output fust_row_t ls_row,
    input  logic      ls_ready
);

    logic      alu_v;
    logic      ls_v;
    fust_row_t alu_q;
    fust_row_t ls_q;
    fust_row_t alu_src;
    fust_row_t ls_src;

    // capture a broadcast that matches both producer unit and source register
    function automatic fust_row_t wake(fust_row_t row, wb_t wb);
        fust_row_t r;
        r = row;
        if (wb.valid && r.tag1 == wb.tag && r.rs1 == wb.rd) begin
            r.tag1 = TAG_NONE;
            r.val1 = wb.value;
        end
        if (wb.valid && r.tag2 == wb.tag && r.rs2 == wb.rd) begin
            r.tag2 = TAG_NONE;
            r.val2 = wb.value;
        end
        return r;
    endfunction

    // new row gets the same wake-up, covering same cycle bypass
    assign alu_src = alloc_alu ? alloc_row : alu_q;
    assign ls_src  = alloc_ls ? alloc_row : ls_q;

    always_ff @(posedge CLK) begin
        alu_q <= wake(wake(alu_src, alu_wb), ls_wb);
        ls_q  <= wake(wake(ls_src, alu_wb), ls_wb);
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            alu_v <= 1'b0;
            ls_v  <= 1'b0;
        end else begin
            // row frees at the issue edge
            alu_v <= alloc_alu || (alu_v && !alu_issue);
            ls_v  <= alloc_ls || (ls_v && !ls_issue);
        end
    end

    assign alu_busy = alu_v;
    assign ls_busy  = ls_v;
    assign alu_row  = alu_q;
    assign ls_row   = ls_q;

    assign alu_issue = alu_v && (alu_q.tag1 == TAG_NONE) && (alu_q.tag2 == TAG_NONE);
    assign ls_issue  = ls_v && (ls_q.tag1 == TAG_NONE) && (ls_q.tag2 == TAG_NONE) && ls_ready;

    property p_clean_issue(logic issue, fust_row_t row);
        @(posedge CLK) disable iff (!nRST)
        issue |-> row.tag1 == TAG_NONE && row.tag2 == TAG_NONE;
    endproperty

    // a waiting row is never replaced by a new allocation
    property p_hold(logic v, logic issue, fust_row_t row);
        @(posedge CLK) disable iff (!nRST)
        v && !issue |=> v && row.op == $past(row.op) && row.rd == $past(row.rd);
    endproperty

    // allocation only lands in an empty row
    property p_alloc_free(logic alloc, logic v);
        @(posedge CLK) disable iff (!nRST)
        alloc |-> !v;
    endproperty

    a_alu_clean: assert property (p_clean_issue(alu_issue, alu_q))
        else $error("fu_status_table: alu row issued with a pending tag");
    a_ls_clean: assert property (p_clean_issue(ls_issue, ls_q))
        else $error("fu_status_table: load/store row issued with a pending tag");
    a_alu_hold: assert property (p_hold(alu_v, alu_issue, alu_q))
        else $error("fu_status_table: waiting alu row overwritten");
    a_ls_hold: assert property (p_hold(ls_v, ls_issue, ls_q))
        else $error("fu_status_table: waiting load/store row overwritten");
    a_alu_alloc_free: assert property (p_alloc_free(alloc_alu, alu_v))
        else $error("fu_status_table: allocation into an occupied alu row");
    a_ls_alloc_free: assert property (p_alloc_free(alloc_ls, ls_v))
        else $error("fu_status_table: allocation into an occupied load/store row");

endmodule

// ==== dispatch.sv ====
module dispatch import isa_pkg::*, sched_pkg::*; (
    input  logic      in_valid,
    input  word_t     in_instr,
    output logic      in_ready,
    output regidx_t   rd_addr1,
    output regidx_t   rd_addr2,
    output regidx_t   rd_addr3,
    input  fu_tag_t   rd_tag1,
    input  fu_tag_t   rd_tag2,
    input  fu_tag_t   rd_tag3,
    input  word_t     rd_val1,
    input  word_t     rd_val2,
    output logic      set_en,
    output regidx_t   set_rd,
    output fu_tag_t   set_tag,
    input  logic      alu_busy,
    input  logic      ls_busy,
    output logic      alloc_alu,
    output logic      alloc_ls,
    output fust_row_t alloc_row
);

    decoded_t dec;
    logic     struct_haz;
    logic     waw_haz;
    logic     accept;

    instr_decoder u_instr_decoder (
        .instr (in_instr),
        .dec   (dec)
    );

    assign rd_addr1 = dec.rs1;
    assign rd_addr2 = dec.rs2;
    assign rd_addr3 = dec.rd;

    // target unit row still holds an instruction
    always_comb begin
        case (dec.fu)
            TAG_ALU: struct_haz = alu_busy;
            TAG_LS:  struct_haz = ls_busy;
            default: struct_haz = 1'b0;
        endcase
    end

    // one writer in flight per register
    assign waw_haz = dec.reg_write && (rd_tag3 != TAG_NONE);

    assign in_ready = !(struct_haz || waw_haz);
    assign accept   = in_valid && in_ready;

    // a nop has no unit, so it is taken and dropped
    assign alloc_alu = accept && (dec.fu == TAG_ALU);
    assign alloc_ls  = accept && (dec.fu == TAG_LS);

    assign set_en  = accept && dec.reg_write;
    assign set_rd  = dec.rd;
    assign set_tag = dec.fu;

    always_comb begin
        alloc_row      = '0;
        alloc_row.op   = dec.op;
        alloc_row.rd   = dec.rd;
        alloc_row.rs1  = dec.rs1;
        alloc_row.rs2  = dec.rs2;
        alloc_row.imm  = dec.imm;
        alloc_row.val1 = rd_val1;
        alloc_row.val2 = rd_val2;
        alloc_row.tag1 = TAG_NONE;
        alloc_row.tag2 = TAG_NONE;
        // operands the op ignores never wait
        if (dec.op != OP_NOP) begin
            alloc_row.tag1 = rd_tag1;
        end
        if (dec.uses_rs2) begin
            alloc_row.tag2 = rd_tag2;
        end
    end

endmodule

// ==== reg_file_status.sv ====
module reg_file_status import isa_pkg::*, sched_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  regidx_t rd_addr1,
    input  regidx_t rd_addr2,
    input  regidx_t rd_addr3,
    output fu_tag_t rd_tag1,
    output fu_tag_t rd_tag2,
    output fu_tag_t rd_tag3,
    output word_t   rd_val1,
    output word_t   rd_val2,
    input  logic    set_en,
    input  regidx_t set_rd,
    input  fu_tag_t set_tag,
    input  wb_t     alu_wb,
    input  wb_t     ls_wb
);

    word_t   regs [32];
    fu_tag_t tags [32];
    wb_t     wbs  [2];

    assign wbs[0] = alu_wb;
    assign wbs[1] = ls_wb;

    // entry 0 is never written, so x0 reads zero and free
    assign rd_val1 = regs[rd_addr1];
    assign rd_val2 = regs[rd_addr2];
    assign rd_tag1 = tags[rd_addr1];
    assign rd_tag2 = tags[rd_addr2];
    // third port only looks at the destination status
    assign rd_tag3 = tags[rd_addr3];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
                tags[i] <= TAG_NONE;
            end
        end else begin
            // retire only if the broadcast comes from the current owner
            for (int w = 0; w < 2; w++) begin
                if (wbs[w].valid && wbs[w].rd != '0 && tags[wbs[w].rd] == wbs[w].tag) begin
                    regs[wbs[w].rd] <= wbs[w].value;
                    tags[wbs[w].rd] <= TAG_NONE;
                end
            end
            // dispatch never claims a register that is still busy
            if (set_en && set_rd != '0) begin
                tags[set_rd] <= set_tag;
            end
        end
    end

    // the WAW stall in dispatch keeps one owner per register
    property p_wb_owner(wb_t wb);
        @(posedge CLK) disable iff (!nRST)
        wb.valid |-> tags[wb.rd] == wb.tag;
    endproperty

    a_alu_owner: assert property (p_wb_owner(alu_wb))
        else $error("reg_file_status: alu broadcast to x%0d not owned", alu_wb.rd);
    a_ls_owner: assert property (p_wb_owner(ls_wb))
        else $error("reg_file_status: load broadcast to x%0d not owned", ls_wb.rd);

endmodule

// ==== instr_decoder.sv ====
module instr_decoder import isa_pkg::*, sched_pkg::*; (
    input  word_t    instr,
    output decoded_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // sign extended I and S immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        dec     = '0;
        dec.op  = OP_NOP;
        dec.rd  = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.imm = imm_i;
        dec.fu  = TAG_NONE;

        case (opcode)
            OPC_OP: begin
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}: dec.op = OP_ADD;
                    {F7_ALT, F3_ADD}:  dec.op = OP_SUB;
                    {F7_BASE, F3_AND}: dec.op = OP_AND;
                    {F7_BASE, F3_XOR}: dec.op = OP_XOR;
                    default:           dec.op = OP_NOP;
                endcase
            end
            OPC_OP_IMM: begin
                if (funct3 == F3_ADD) begin
                    dec.op = OP_ADDI;
                end
            end
            OPC_LOAD: begin
                if (funct3 == F3_WORD) begin
                    dec.op = OP_LW;
                end
            end
            OPC_STORE: begin
                dec.imm = imm_s;
                if (funct3 == F3_WORD) begin
                    dec.op = OP_SW;
                end
            end
            default: dec.op = OP_NOP;
        endcase

        // control follows the operation
        case (dec.op)
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                dec.fu        = TAG_ALU;
                dec.uses_rs2  = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_ADDI: begin
                dec.fu        = TAG_ALU;
                dec.reg_write = 1'b1;
            end
            OP_LW: begin
                dec.fu        = TAG_LS;
                dec.reg_write = 1'b1;
            end
            OP_SW: begin
                dec.fu       = TAG_LS;
                dec.uses_rs2 = 1'b1;
            end
            default: dec.fu = TAG_NONE;
        endcase

        // x0 stays zero
        if (dec.rd == '0) begin
            dec.reg_write = 1'b0;
        end
    end

endmodule

// ==== sched_pkg.sv ====
package sched_pkg;

    import isa_pkg::*;

    // producer tags, one code per unit
    typedef logic [1:0] fu_tag_t;

    localparam fu_tag_t TAG_NONE = 2'd0;
    localparam fu_tag_t TAG_ALU  = 2'd1;
    localparam fu_tag_t TAG_LS   = 2'd2;

    localparam int LS_LATENCY = 3;
    localparam int LS_CNT_W   = $clog2(LS_LATENCY + 1);
    localparam int MEM_WORDS  = 16;

    typedef logic [LS_CNT_W-1:0]          lscnt_t;
    typedef logic [$clog2(MEM_WORDS)-1:0] memidx_t;

    // one waiting instruction, values valid once its tag is clear
    typedef struct packed {
        op_t     op;
        regidx_t rd;
        regidx_t rs1;
        regidx_t rs2;
        fu_tag_t tag1;
        fu_tag_t tag2;
        word_t   val1;
        word_t   val2;
        word_t   imm;
    } fust_row_t;

    typedef struct packed {
        logic    valid;
        fu_tag_t tag;
        regidx_t rd;
        word_t   value;
    } wb_t;

    typedef struct packed {
        op_t     op;
        regidx_t rd;
        regidx_t rs1;
        regidx_t rs2;
        word_t   imm;
        logic    reg_write;
        fu_tag_t fu;
        logic    uses_rs2;
    } decoded_t;

    typedef enum logic {
        LS_IDLE,
        LS_BUSY
    } ls_state_t;

endpackage

// ==== isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regidx_t;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 codes of the subset
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;

    // funct7 picks add or sub
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_ADDI,
        OP_LW,
        OP_SW,
        OP_NOP
    } op_t;

endpackage
